//--- vlog.f
src/mem_pkg.sv
src/req_pipe_queue.sv
src/mem_access_stage.sv
src/resp_bypass_queue.sv
src/test_mem.sv
tests/test_mem_sva.sv
tests/test_mem_tb.sv

//--- run.sh
#!/bin/sh
# Builds the test memory simulation with Verilator and runs it
# The exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module test_mem_tb \
  -o test_mem_sim

./obj_dir/test_mem_sim

//--- tests/test_mem_tb.sv
/*
  Directed and random traffic for the test memory, checked against a reference model
  The model updates at request acceptance, so mem_clear_i is raised only when idle
  One-cycle latency and full throughput are checked only while back-pressure is off
*/
`timescale 1ns/1ps

module test_mem_tb
  import mem_pkg::*;
();

  localparam int NUM_REQS   = 400;
  localparam int MAX_CYCLES = NUM_REQS * 8 + 200;

  typedef struct packed {
    req_type_t rtype;
    opaque_t   opaque;
    len_t      len;
    data_t     data;
  } exp_resp_t;

  logic      clk = 1'b0;
  logic      reset;
  logic      mem_clear;
  logic      req_val;
  logic      req_rdy;
  req_type_t req_type;
  opaque_t   req_opaque;
  addr_t     req_addr;
  len_t      req_len;
  data_t     req_data;
  logic      resp_val;
  logic      resp_rdy;
  req_type_t resp_type;
  opaque_t   resp_opaque;
  len_t      resp_len;
  data_t     resp_data;

  data_t       model_mem [NUM_WORDS];
  exp_resp_t   exp_q [$];
  logic [31:0] lcg_state = 32'd43;
  int          sent = 0;
  int          checked = 0;
  int          cycles = 0;
  opaque_t     next_tag = '0;
  logic        bp_en = 1'b0;

  test_mem dut0 (
    .clk           (clk),
    .reset         (reset),
    .mem_clear_i   (mem_clear),
    .req_val_i     (req_val),
    .req_rdy_o     (req_rdy),
    .req_type_i    (req_type),
    .req_opaque_i  (req_opaque),
    .req_addr_i    (req_addr),
    .req_len_i     (req_len),
    .req_data_i    (req_data),
    .resp_val_o    (resp_val),
    .resp_rdy_i    (resp_rdy),
    .resp_type_o   (resp_type),
    .resp_opaque_o (resp_opaque),
    .resp_len_o    (resp_len),
    .resp_data_o   (resp_data)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------------------------------

  // LCG returns its upper half since the low bits repeat quickly
  function automatic logic [15:0] lcg_rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // Applies one request to the model and returns the expected response data
  function automatic data_t ref_access(input req_type_t t, input addr_t a, input len_t l,
                                       input data_t d);
    word_idx_t idx;
    byte_off_t off;
    data_t     old;
    data_t     upd;
    int        nbytes;
    idx    = a[9:2];
    off    = a[1:0];
    old    = model_mem[idx];
    upd    = old;
    nbytes = (l == 2'd0) ? 4 : int'(l);
    case (t)
      TYPE_WRITE, TYPE_WRITE_INIT: begin
        // Bytes past the word end are lost
        for (int i = 0; i < nbytes; i++) begin
          if (int'(off) + i < 4) begin
            upd[(int'(off) + i) * 8 +: 8] = d[i * 8 +: 8];
          end
        end
      end
      TYPE_AMO_ADD: upd = old + d;
      TYPE_AMO_AND: upd = old & d;
      TYPE_AMO_OR:  upd = old | d;
      default:      upd = old;
    endcase
    model_mem[idx] = upd;
    return old >> (8 * int'(off));
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------

  task automatic report_mismatch(input string name, input string exp, input string act);
    $display("CHECK FAILED time=%0t signal=%s expected=%s actual=%s", $time, name, exp, act);
    $display(">>> FAIL");
    $fatal(1, "Response field mismatch");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_opaque(input string name, input opaque_t exp, input opaque_t act);
    if (act !== exp) begin
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_type(input string name, input req_type_t exp, input req_type_t act);
    if (act !== exp) begin
      report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    end
  endtask

  task automatic check_len(input string name, input len_t exp, input len_t act);
    if (act !== exp) begin
      report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    end
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard and timeout
  // --------------------------------------------------------------------------

  // Sampled mid-cycle while inputs are stable
  always @(negedge clk) begin
    exp_resp_t want;
    if (reset) begin
      // Pop before push since a response never belongs to a request of this cycle
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: a response arrived with no request outstanding", $time);
          $display(">>> FAIL");
          $fatal(1, "Unexpected response");
        end else begin
          want = exp_q.pop_front();
          check_type("resp_type_o", want.rtype, resp_type);
          check_opaque("resp_opaque_o", want.opaque, resp_opaque);
          check_len("resp_len_o", want.len, resp_len);
          check_data("resp_data_o", want.data, resp_data);
          checked++;
        end
      end
      // Without back-pressure every request is taken at once
      // and its response leaves one cycle later
      if (!bp_en) begin
        check_flag("req_rdy_o", 1'b1, req_rdy);
        if (exp_q.size() != 0) begin
          $display("Error at %0t: a response did not leave one cycle after its request",
                   $time);
          $display(">>> FAIL");
          $fatal(1, "Late response");
        end
      end
      if (req_val && req_rdy) begin
        want.rtype  = req_type;
        want.opaque = req_opaque;
        want.len    = req_len;
        want.data   = ref_access(req_type, req_addr, req_len, req_data);
        exp_q.push_back(want);
      end
      if (mem_clear) begin
        model_mem = '{default: '0};
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d responses checked",
               MAX_CYCLES, checked, sent);
      $display(">>> FAIL");
      $fatal(1, "Timeout");
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // Move to 1 ns past the next rising edge and redraw back-pressure (~70% ready)
  task automatic next_cycle();
    @(posedge clk);
    #1;
    resp_rdy = bp_en ? ((lcg_rand16() % 16'd10) < 16'd7) : 1'b1;
  endtask

  // Hold one request until the DUT takes it
  task automatic send_req(input req_type_t t, input addr_t a, input len_t l, input data_t d);
    logic taken;
    req_val    = 1'b1;
    req_type   = t;
    req_opaque = next_tag;
    req_addr   = a;
    req_len    = l;
    req_data   = d;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = req_rdy;
      next_cycle();
    end
    req_val  = 1'b0;
    next_tag = next_tag + 8'd1;
    sent++;
  endtask

  // Drain all responses, then clear for one cycle
  task automatic clear_mem();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    mem_clear = 1'b1;
    next_cycle();
    mem_clear = 1'b0;
  endtask

  initial begin
    addr_t       a;
    logic [15:0] r;
    logic [15:0] pick;
    reset      = 1'b0;
    mem_clear  = 1'b0;
    req_val    = 1'b0;
    req_type   = TYPE_READ;
    req_opaque = '0;
    req_addr   = '0;
    req_len    = '0;
    req_data   = '0;
    resp_rdy   = 1'b1;
    repeat (8) next_cycle();
    reset = 1'b1;
    clear_mem();

    // Full-word writes, then reads of the same words
    for (int i = 0; i < 16; i++) begin
      send_req(TYPE_WRITE, {22'd0, 8'(i * 5), 2'b00}, 2'd0, {lcg_rand16(), lcg_rand16()});
    end
    for (int i = 0; i < 16; i++) begin
      send_req(TYPE_READ, {22'd0, 8'(i * 5), 2'b00}, 2'd0, '0);
    end

    // Partial writes over a known pattern, every length and offset
    // The full-word read also covers the bytes below the offset
    for (int i = 0; i < 16; i++) begin
      a = {22'd0, 8'(100 + i), 2'(i)};
      send_req(TYPE_WRITE, {a[31:2], 2'b00}, 2'd0, 32'hc3a5_5a3c);
      send_req(TYPE_WRITE, a, 2'(i / 4), {lcg_rand16(), lcg_rand16()});
      send_req(TYPE_READ, a, 2'(i), '0);
      send_req(TYPE_READ, {a[31:2], 2'b00}, 2'd0, '0);
    end

    // Atomics on written words, each followed by a read
    for (int i = 0; i < 9; i++) begin
      a = {22'd0, 8'(i * 5), 2'b00};
      send_req(3'(3 + i % 3), a, 2'd0, {lcg_rand16(), lcg_rand16()});
      send_req(TYPE_READ, a, 2'd0, '0);
    end

    // Write-init through aliased high addresses
    for (int i = 0; i < 8; i++) begin
      r = lcg_rand16();
      a = {1'b1, r[14:0], 6'd0, r[7:0], 2'b00};
      send_req(TYPE_WRITE_INIT, a, 2'd0, {lcg_rand16(), lcg_rand16()});
      send_req(TYPE_READ, {22'd0, a[9:0]}, 2'd0, '0);
    end

    // Earlier words read back as zero after a clear
    clear_mem();
    for (int i = 0; i < 16; i++) begin
      send_req(TYPE_READ, {22'd0, 8'(i * 5), 2'b00}, 2'd0, '0);
    end

    // Random mix under random back-pressure
    bp_en = 1'b1;
    while (sent < NUM_REQS) begin
      r    = lcg_rand16();
      pick = lcg_rand16() % 16'd6;
      send_req(pick[2:0], {22'd0, r[9:0]}, r[11:10], {lcg_rand16(), lcg_rand16()});
      if (r[15:13] == 3'd0) begin
        next_cycle();
      end
    end

    // Back-pressure stays on until every response is in
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    bp_en = 1'b0;
    // A few idle cycles catch any stray response
    repeat (4) next_cycle();
    if (checked == sent) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Response count wrong, %0d requests sent and %0d checked", sent, checked);
      $display(">>> FAIL");
      $fatal(1, "Response count");
    end
  end

endmodule

//--- tests/test_mem_sva.sv
/*
  Handshake and reset assertions, bound to every test_mem instance
  Checks other than the reset check are disabled while reset is low
*/
`timescale 1ns/1ps

module test_mem_sva
  import mem_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      req_val_i,
  input logic      req_rdy_i,
  input logic      resp_val_i,
  input logic      resp_rdy_i,
  input req_type_t resp_type_i,
  input opaque_t   resp_opaque_i,
  input len_t      resp_len_i,
  input data_t     resp_data_i
);

  // Request valid must be driven once reset is released
  req_val_known: assert property (@(posedge clk) reset |-> !$isunknown(req_val_i))
    else $error("req_val_i is unknown after reset");

  // Both queues come out of reset empty
  resp_idle_after_reset: assert property (@(posedge clk) !reset |=> !resp_val_i)
    else $error("resp_val_o is high in the cycle after reset");

  // A stalled response keeps its valid and every field
  resp_held: assert property (@(posedge clk) disable iff (!reset)
    (resp_val_i && !resp_rdy_i) |=> (resp_val_i && $stable(resp_type_i) &&
      $stable(resp_opaque_i) && $stable(resp_len_i) && $stable(resp_data_i)))
    else $error("response changed while stalled");

  // Nothing in flight means the pipe queue is empty
  req_rdy_when_idle: assert property (@(posedge clk) disable iff (!reset)
    !resp_val_i |-> req_rdy_i)
    else $error("req_rdy_o is low with no response pending");

endmodule

bind test_mem test_mem_sva sva0 (
  .clk           (clk),
  .reset         (reset),
  .req_val_i     (req_val_i),
  .req_rdy_i     (req_rdy_o),
  .resp_val_i    (resp_val_o),
  .resp_rdy_i    (resp_rdy_i),
  .resp_type_i   (resp_type_o),
  .resp_opaque_i (resp_opaque_o),
  .resp_len_i    (resp_len_o),
  .resp_data_i   (resp_data_o)
);

//--- src/test_mem.sv
/*
  Single-ported test memory: pipe queue, access stage, bypass queue
  One cycle latency and one request per cycle with no back-pressure
  Array contents are undefined until mem_clear_i is asserted
*/
`timescale 1ns/1ps

module test_mem
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Clears the whole array to zero
  input  logic      mem_clear_i,

  // Request port
  input  logic      req_val_i,
  output logic      req_rdy_o,
  input  req_type_t req_type_i,
  input  opaque_t   req_opaque_i,
  input  addr_t     req_addr_i,
  input  len_t      req_len_i,
  input  data_t     req_data_i,

  // Response port
  output logic      resp_val_o,
  input  logic      resp_rdy_i,
  output req_type_t resp_type_o,
  output opaque_t   resp_opaque_o,
  output len_t      resp_len_o,
  output data_t     resp_data_o
);

  // --------------------------------------------------------------------------
  // Registered request link
  // --------------------------------------------------------------------------

  logic      req_val_m;
  logic      req_rdy_m;
  req_type_t req_type_m;
  opaque_t   req_opaque_m;
  addr_t     req_addr_m;
  len_t      req_len_m;
  data_t     req_data_m;

  req_pipe_queue req_q0 (
    .clk          (clk),
    .reset        (reset),
    .enq_val_i    (req_val_i),
    .enq_rdy_o    (req_rdy_o),
    .enq_type_i   (req_type_i),
    .enq_opaque_i (req_opaque_i),
    .enq_addr_i   (req_addr_i),
    .enq_len_i    (req_len_i),
    .enq_data_i   (req_data_i),
    .deq_val_o    (req_val_m),
    .deq_rdy_i    (req_rdy_m),
    .deq_type_o   (req_type_m),
    .deq_opaque_o (req_opaque_m),
    .deq_addr_o   (req_addr_m),
    .deq_len_o    (req_len_m),
    .deq_data_o   (req_data_m)
  );

  // --------------------------------------------------------------------------
  // Access stage and response link
  // --------------------------------------------------------------------------

  logic      resp_val_e;
  logic      resp_rdy_e;
  req_type_t resp_type_e;
  opaque_t   resp_opaque_e;
  len_t      resp_len_e;
  data_t     resp_data_e;

  mem_access_stage access0 (
    .clk           (clk),
    .mem_clear_i   (mem_clear_i),
    .req_val_i     (req_val_m),
    .req_rdy_o     (req_rdy_m),
    .req_type_i    (req_type_m),
    .req_opaque_i  (req_opaque_m),
    .req_addr_i    (req_addr_m),
    .req_len_i     (req_len_m),
    .req_data_i    (req_data_m),
    .resp_val_o    (resp_val_e),
    .resp_rdy_i    (resp_rdy_e),
    .resp_type_o   (resp_type_e),
    .resp_opaque_o (resp_opaque_e),
    .resp_len_o    (resp_len_e),
    .resp_data_o   (resp_data_e)
  );

  // Output buffer absorbs a stalled response without adding latency
  resp_bypass_queue resp_q0 (
    .clk          (clk),
    .reset        (reset),
    .enq_val_i    (resp_val_e),
    .enq_rdy_o    (resp_rdy_e),
    .enq_type_i   (resp_type_e),
    .enq_opaque_i (resp_opaque_e),
    .enq_len_i    (resp_len_e),
    .enq_data_i   (resp_data_e),
    .deq_val_o    (resp_val_o),
    .deq_rdy_i    (resp_rdy_i),
    .deq_type_o   (resp_type_o),
    .deq_opaque_o (resp_opaque_o),
    .deq_len_o    (resp_len_o),
    .deq_data_o   (resp_data_o)
  );

endmodule

//--- src/resp_bypass_queue.sv
/*
  One-entry bypass queue for response fields
  When empty the incoming response passes straight through with no latency
  A stored entry blocks enqueue until it is dequeued
*/
`timescale 1ns/1ps

module resp_bypass_queue
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Enqueue side
  input  logic      enq_val_i,
  output logic      enq_rdy_o,
  input  req_type_t enq_type_i,
  input  opaque_t   enq_opaque_i,
  input  len_t      enq_len_i,
  input  data_t     enq_data_i,

  // Dequeue side
  output logic      deq_val_o,
  input  logic      deq_rdy_i,
  output req_type_t deq_type_o,
  output opaque_t   deq_opaque_o,
  output len_t      deq_len_o,
  output data_t     deq_data_o
);

  logic      full;
  logic      store;
  req_type_t held_type;
  opaque_t   held_opaque;
  len_t      held_len;
  data_t     held_data;

  assign enq_rdy_o = !full;

  // Keep the incoming entry only if the consumer does not take it now
  assign store = enq_val_i && !full && !deq_rdy_i;

  always_ff @(posedge clk) begin
    if (!reset) begin
      full <= 1'b0;
    end else if (store) begin
      full <= 1'b1;
    end else if (full && deq_rdy_i) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      held_type   <= enq_type_i;
      held_opaque <= enq_opaque_i;
      held_len    <= enq_len_i;
      held_data   <= enq_data_i;
    end
  end

  // Held entry first, otherwise the bypass path
  assign deq_val_o    = full || enq_val_i;
  assign deq_type_o   = full ? held_type   : enq_type_i;
  assign deq_opaque_o = full ? held_opaque : enq_opaque_i;
  assign deq_len_o    = full ? held_len    : enq_len_i;
  assign deq_data_o   = full ? held_data   : enq_data_i;

endmodule

//--- src/mem_access_stage.sv
/*
  Memory access stage of the test memory, combinational except for the array write
  Addresses are truncated to the physical size, so high addresses alias
  Writes and atomics take effect only on a transfer; every response returns the
  old word shifted by the byte offset. The array has no reset, use mem_clear_i
*/
`timescale 1ns/1ps

module mem_access_stage
  import mem_pkg::*;
(
  input  logic      clk,

  // Clears every word to zero
  input  logic      mem_clear_i,

  // Request side
  input  logic      req_val_i,
  output logic      req_rdy_o,
  input  req_type_t req_type_i,
  input  opaque_t   req_opaque_i,
  input  addr_t     req_addr_i,
  input  len_t      req_len_i,
  input  data_t     req_data_i,

  // Response side
  output logic      resp_val_o,
  input  logic      resp_rdy_i,
  output req_type_t resp_type_o,
  output opaque_t   resp_opaque_o,
  output len_t      resp_len_o,
  output data_t     resp_data_o
);

  // --------------------------------------------------------------------------
  // Word array and address decode
  // --------------------------------------------------------------------------

  data_t mem_array [NUM_WORDS];

  logic [PHYS_ADDR_NBITS-1:0] phys_addr;
  word_idx_t                  word_idx;
  byte_off_t                  byte_off;

  // Drop address bits above the physical memory size
  assign phys_addr = req_addr_i[PHYS_ADDR_NBITS-1:0];
  assign word_idx  = phys_addr[PHYS_ADDR_NBITS-1:$bits(byte_off_t)];
  assign byte_off  = phys_addr[$bits(byte_off_t)-1:0];

  // Length field of 0 stands for a full word
  logic [2:0] len_bytes;
  assign len_bytes = (req_len_i == '0) ? 3'(DATA_NBYTES) : {1'b0, req_len_i};

  // Word as it stands before this request
  data_t old_word;
  assign old_word = mem_array[word_idx];

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Request leaves in the same cycle the response enters the output queue
  logic xfer;
  assign req_rdy_o  = resp_rdy_i;
  assign resp_val_o = req_val_i;
  assign xfer       = req_val_i && req_rdy_o;

  // --------------------------------------------------------------------------
  // Byte-masked write data
  // --------------------------------------------------------------------------

  data_t merge_word;

  // Request byte i lands at word byte offset+i
  // Bytes past the end of the word are dropped
  always_comb begin
    int src;
    src        = 0;
    merge_word = old_word;
    for (int dst = 0; dst < int'(DATA_NBYTES); dst++) begin
      src = dst - int'(byte_off);
      if (src >= 0 && src < int'(len_bytes)) begin
        merge_word[dst*8 +: 8] = req_data_i[src*8 +: 8];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Update decode
  // --------------------------------------------------------------------------

  data_t next_word;
  logic  store_en;

  // Atomics act on the whole word
  always_comb begin
    store_en  = 1'b0;
    next_word = old_word;
    case (req_type_i)
      TYPE_READ: begin
        store_en = 1'b0;
      end
      TYPE_WRITE, TYPE_WRITE_INIT: begin
        store_en  = 1'b1;
        next_word = merge_word;
      end
      TYPE_AMO_ADD: begin
        store_en  = 1'b1;
        next_word = req_data_i + old_word;
      end
      TYPE_AMO_AND: begin
        store_en  = 1'b1;
        next_word = req_data_i & old_word;
      end
      TYPE_AMO_OR: begin
        store_en  = 1'b1;
        next_word = req_data_i | old_word;
      end
      default: begin
        // Unknown types behave as reads
        store_en = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Array write and clear
  // --------------------------------------------------------------------------

  // Clear wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (mem_clear_i) begin
      for (int i = 0; i < int'(NUM_WORDS); i++) begin
        mem_array[i] <= '0;
      end
    end else if (xfer && store_en) begin
      mem_array[word_idx] <= next_word;
    end
  end

  // --------------------------------------------------------------------------
  // Response fields
  // --------------------------------------------------------------------------

  assign resp_type_o   = req_type_i;
  assign resp_opaque_o = req_opaque_i;
  assign resp_len_o    = req_len_i;

  // Prior value, aligned down by the byte offset
  assign resp_data_o   = old_word >> {byte_off, 3'b000};

endmodule

//--- src/req_pipe_queue.sv
/*
  One-entry pipe queue for request fields
  Accepts a new entry in the same cycle the held one is dequeued
  Ready depends combinationally on deq_rdy_i
*/
`timescale 1ns/1ps

module req_pipe_queue
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Enqueue side
  input  logic      enq_val_i,
  output logic      enq_rdy_o,
  input  req_type_t enq_type_i,
  input  opaque_t   enq_opaque_i,
  input  addr_t     enq_addr_i,
  input  len_t      enq_len_i,
  input  data_t     enq_data_i,

  // Dequeue side
  output logic      deq_val_o,
  input  logic      deq_rdy_i,
  output req_type_t deq_type_o,
  output opaque_t   deq_opaque_o,
  output addr_t     deq_addr_o,
  output len_t      deq_len_o,
  output data_t     deq_data_o
);

  logic full;
  logic enq_xfer;
  logic deq_xfer;

  // Room when empty, or when the held entry leaves this cycle
  assign enq_rdy_o = !full || deq_rdy_i;
  assign enq_xfer  = enq_val_i && enq_rdy_o;
  assign deq_xfer  = full && deq_rdy_i;

  // Full flag
  always_ff @(posedge clk) begin
    if (!reset) begin
      full <= 1'b0;
    end else if (enq_xfer) begin
      full <= 1'b1;
    end else if (deq_xfer) begin
      full <= 1'b0;
    end
  end

  // Payload registers, loaded on every enqueue
  always_ff @(posedge clk) begin
    if (enq_xfer) begin
      deq_type_o   <= enq_type_i;
      deq_opaque_o <= enq_opaque_i;
      deq_addr_o   <= enq_addr_i;
      deq_len_o    <= enq_len_i;
      deq_data_o   <= enq_data_i;
    end
  end

  assign deq_val_o = full;

endmodule

//--- src/mem_pkg.sv
/*
  Shared field types, message type codes and size constants for the test memory
  All widths are fixed here, so no module takes parameters
  MEM_NBYTES and DATA_NBYTES must be powers of two
*/
package mem_pkg;

  // --------------------------------------------------------------------------
  // Memory geometry
  // --------------------------------------------------------------------------

  // Physical memory size in bytes
  localparam int unsigned MEM_NBYTES      = 1024;
  // Bytes per data word
  localparam int unsigned DATA_NBYTES     = 4;
  // Words held by the array
  localparam int unsigned NUM_WORDS       = MEM_NBYTES / DATA_NBYTES;
  // Address bits kept after truncation
  localparam int unsigned PHYS_ADDR_NBITS = $clog2(MEM_NBYTES);

  // --------------------------------------------------------------------------
  // Message field types
  // --------------------------------------------------------------------------

  typedef logic [7:0]  opaque_t;    // Tag echoed back in the response
  typedef logic [31:0] addr_t;      // Byte address
  typedef logic [31:0] data_t;      // Data word
  typedef logic [1:0]  len_t;       // Length in bytes, 0 is a full word
  typedef logic [2:0]  req_type_t;  // Message type

  // Address split inside the array
  typedef logic [$clog2(NUM_WORDS)-1:0]   word_idx_t;
  typedef logic [$clog2(DATA_NBYTES)-1:0] byte_off_t;

  // --------------------------------------------------------------------------
  // Message type codes
  // --------------------------------------------------------------------------

  localparam req_type_t TYPE_READ       = 3'd0;
  localparam req_type_t TYPE_WRITE      = 3'd1;
  localparam req_type_t TYPE_WRITE_INIT = 3'd2;
  localparam req_type_t TYPE_AMO_ADD    = 3'd3;
  localparam req_type_t TYPE_AMO_AND    = 3'd4;
  localparam req_type_t TYPE_AMO_OR     = 3'd5;

endpackage
